//--- source/mbox_consts.svh
// mailbox count, FIFO depth, packet layout, node ID and register map constants
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

// sizing
`define MBOX_NUM      4          // mailboxes per node
`define MBOX_DEPTH    16         // entries per FIFO, power of two
`define MBOX_DW       64         // FIFO entry width
`define MBOX_PW       104        // mesh packet width
`define MBOX_RFAW     6          // register index width

// mesh packet fields
`define MBOX_PKT_WR   1          // write flag bit
`define MBOX_PKT_AHI  39         // address msb
`define MBOX_PKT_ALO  8          // address lsb
`define MBOX_PKT_DHI  103        // data msb
`define MBOX_PKT_DLO  40         // data lsb

// address match
`define MBOX_ID       12'h810    // node ID, addr[31:20]
`define MBOX_PAGE     3'h3       // mailbox page, addr[10:8]

// register map, word indices from addr[7:2]
// mailbox k LO at base+2k, HI right after it
`define MBOX_REG_BASE 8          // mailbox 0 LO
`define MBOX_REG_STAT 16         // not-empty bitmap

`endif

//--- source/mbox_pkg.sv
// mailbox entry, index and register types plus register index decode helpers
`include "mbox_consts.svh"

package mbox_pkg;

   localparam int MBOX_IDXW = (`MBOX_NUM > 1) ? $clog2(`MBOX_NUM) : 1; // index bits

   typedef logic [`MBOX_DW-1:0]   mbox_entry_t;  // one FIFO word
   typedef logic [MBOX_IDXW-1:0]  mbox_idx_t;    // selects a mailbox
   typedef logic [`MBOX_RFAW-1:0] mbox_reg_t;    // register word index

   // true when the index falls on any mailbox LO or HI register
   function automatic logic box_reg_hit(mbox_reg_t r);
      mbox_reg_t off;
      off = r - mbox_reg_t'(`MBOX_REG_BASE);   // offset from mailbox 0 LO
      return (r >= mbox_reg_t'(`MBOX_REG_BASE)) && (off < 2 * `MBOX_NUM);
   endfunction

   // mailbox number behind a register index
   function automatic mbox_idx_t reg_box(mbox_reg_t r);
      mbox_reg_t off;
      off = r - mbox_reg_t'(`MBOX_REG_BASE);
      return mbox_idx_t'(off >> 1);            // two regs per box
   endfunction

   // odd offset selects the HI half
   function automatic logic reg_is_hi(mbox_reg_t r);
      mbox_reg_t off;
      off = r - mbox_reg_t'(`MBOX_REG_BASE);
      return off[0];
   endfunction

endpackage

//--- source/emesh_decode.sv
// mesh write packet decoder producing a registered one-hot push strobe and push data
`include "mbox_consts.svh"

module emesh_decode
   import mbox_pkg::*;
(
   input  logic                 wr_clk,
   input  logic                 arst_n,
   input  logic                 emesh_access,
   input  logic [`MBOX_PW-1:0]  emesh_packet,
   output logic [`MBOX_NUM-1:0] push,
   output mbox_entry_t          push_data
);

   logic [31:0]          pkt_addr;   // 32-bit mesh address
   mbox_entry_t          pkt_data;   // payload word
   logic                 pkt_write;  // write flag
   mbox_reg_t            reg_idx;    // word index inside the page
   mbox_idx_t            box;        // target mailbox
   logic                 id_ok;
   logic                 page_ok;
   logic                 lo_ok;      // LO register of some mailbox
   logic                 accept;
   logic [`MBOX_NUM-1:0] box_sel;    // one-hot of box

   // packet fields
   assign pkt_write = emesh_packet[`MBOX_PKT_WR];
   assign pkt_addr  = emesh_packet[`MBOX_PKT_AHI:`MBOX_PKT_ALO];
   assign pkt_data  = emesh_packet[`MBOX_PKT_DHI:`MBOX_PKT_DLO];
   assign reg_idx   = pkt_addr[`MBOX_RFAW+1:2];

   // address match
   assign id_ok   = (pkt_addr[31:20] == `MBOX_ID);
   assign page_ok = (pkt_addr[10:8] == `MBOX_PAGE);
   assign lo_ok   = box_reg_hit(reg_idx) & ~reg_is_hi(reg_idx); // HI writes ignored
   assign box     = reg_box(reg_idx);
   assign box_sel = {{(`MBOX_NUM-1){1'b0}}, 1'b1} << box;

   assign accept = emesh_access & pkt_write & id_ok & page_ok & lo_ok;

   // push strobe, one wr_clk after the packet
   always_ff @(posedge wr_clk or negedge arst_n) begin
      if (!arst_n) begin
         push <= '0;
      end else begin
         push <= accept ? box_sel : '0; // one-hot or idle
      end
   end

   // payload follows the strobe
   always_ff @(posedge wr_clk) begin
      if (accept) begin
         push_data <= pkt_data;
      end
   end

endmodule

//--- source/fifo_async.sv
// dual-clock FIFO with gray-coded pointers, two-flop synchronizers and show-ahead read
`include "mbox_consts.svh"

module fifo_async
   import mbox_pkg::*;
(
   input  logic        wr_clk,
   input  logic        rd_clk,
   input  logic        arst_n,
   input  logic        wr_en,
   input  mbox_entry_t din,
   output logic        full,
   input  logic        rd_en,
   output mbox_entry_t dout,
   output logic        empty
);

   localparam int AW = $clog2(`MBOX_DEPTH); // address bits, pointers carry one more

   mbox_entry_t mem [`MBOX_DEPTH];          // storage

   // write side pointers
   logic [AW:0] wbin;
   logic [AW:0] wbin_next;
   logic [AW:0] wgray;
   logic [AW:0] wgray_next;
   logic [AW:0] wq1_rgray;                  // read ptr, sync stage 1
   logic [AW:0] wq2_rgray;                  // read ptr, sync stage 2
   logic        wr_ok;

   // read side pointers
   logic [AW:0] rbin;
   logic [AW:0] rbin_next;
   logic [AW:0] rgray;
   logic [AW:0] rgray_next;
   logic [AW:0] rq1_wgray;                  // write ptr, sync stage 1
   logic [AW:0] rq2_wgray;                  // write ptr, sync stage 2
   logic        rd_ok;

   // write domain
   assign wr_ok      = wr_en & ~full;       // push into full is dropped
   assign wbin_next  = wbin + {{AW{1'b0}}, wr_ok};
   assign wgray_next = (wbin_next >> 1) ^ wbin_next;

   always_ff @(posedge wr_clk) begin
      if (wr_ok) begin
         mem[wbin[AW-1:0]] <= din;
      end
   end

   always_ff @(posedge wr_clk or negedge arst_n) begin
      if (!arst_n) begin
         wbin      <= '0;
         wgray     <= '0;
         wq1_rgray <= '0;
         wq2_rgray <= '0;
         full      <= 1'b0;
      end else begin
         wbin      <= wbin_next;
         wgray     <= wgray_next;
         wq1_rgray <= rgray;                // crosses from rd_clk
         wq2_rgray <= wq1_rgray;
         // full when the two msbs differ and the rest match
         full      <= (wgray_next == {~wq2_rgray[AW:AW-1], wq2_rgray[AW-2:0]});
      end
   end

   // read domain
   assign rd_ok      = rd_en & ~empty;      // pop from empty ignored
   assign rbin_next  = rbin + {{AW{1'b0}}, rd_ok};
   assign rgray_next = (rbin_next >> 1) ^ rbin_next;

   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         rbin      <= '0;
         rgray     <= '0;
         rq1_wgray <= '0;
         rq2_wgray <= '0;
         empty     <= 1'b1;
      end else begin
         rbin      <= rbin_next;
         rgray     <= rgray_next;
         rq1_wgray <= wgray;                // crosses from wr_clk
         rq2_wgray <= rq1_wgray;
         empty     <= (rgray_next == rq2_wgray);
      end
   end

   // head entry always on the output
   assign dout = mem[rbin[AW-1:0]];

endmodule

//--- source/emailbox.sv
// single mailbox with its async FIFO, pop control and registered read data
`include "mbox_consts.svh"

module emailbox
   import mbox_pkg::*;
(
   input  logic        rd_clk,
   input  logic        wr_clk,
   input  logic        arst_n,
   input  logic        push,
   input  mbox_entry_t push_data,
   input  logic        rd_lo,
   input  logic        rd_hi,
   output mbox_entry_t box_dout,
   output logic        box_not_empty,
   output logic        box_full
);

   localparam int HW = `MBOX_DW / 2;       // half word

   mbox_entry_t fifo_dout;                 // head entry
   logic        fifo_empty;
   logic        pop;
   logic [HW-1:0] head_hi;                 // upper half of head

   assign pop     = rd_hi & ~fifo_empty;   // HI read consumes the entry
   assign head_hi = fifo_dout[`MBOX_DW-1:HW];

   fifo_async u_fifo (
      .wr_clk (wr_clk),
      .rd_clk (rd_clk),
      .arst_n (arst_n),
      .wr_en  (push),
      .din    (push_data),
      .full   (box_full),
      .rd_en  (pop),
      .dout   (fifo_dout),
      .empty  (fifo_empty)
   );

   // level interrupt
   assign box_not_empty = ~fifo_empty;

   // read data, valid one cycle after the strobe, zero otherwise
   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         box_dout <= '0;
      end else if (rd_lo) begin
         box_dout <= fifo_dout;            // peek, no pop
      end else if (rd_hi) begin
         box_dout <= {head_hi, head_hi};   // upper half in both halves
      end else begin
         box_dout <= '0;                   // keeps the OR bus clean
      end
   end

endmodule

//--- source/mi_read_mux.sv
// register read decode into per-mailbox strobes, status register and read data merge
`include "mbox_consts.svh"

module mi_read_mux
   import mbox_pkg::*;
(
   input  logic                 rd_clk,
   input  logic                 arst_n,
   input  logic                 mi_en,
   input  logic                 mi_we,
   input  logic [`MBOX_RFAW+1:0] mi_addr,
   input  mbox_entry_t          box_dout [`MBOX_NUM],
   input  logic [`MBOX_NUM-1:0] box_not_empty,
   output logic [`MBOX_NUM-1:0] rd_lo,
   output logic [`MBOX_NUM-1:0] rd_hi,
   output logic [`MBOX_DW-1:0]  mi_dout
);

   logic        mi_rd;                     // read cycle
   mbox_reg_t   rd_idx;                    // word index, byte bits dropped
   mbox_idx_t   box;
   logic        box_hit;                   // a mailbox register is read
   logic        hi_sel;
   logic        stat_hit;
   mbox_entry_t stat_q;                    // registered status word

   assign mi_rd    = mi_en & ~mi_we;       // writes ignored
   assign rd_idx   = mi_addr[`MBOX_RFAW+1:2];
   assign box      = reg_box(rd_idx);
   assign hi_sel   = reg_is_hi(rd_idx);
   assign box_hit  = mi_rd & box_reg_hit(rd_idx);
   assign stat_hit = mi_rd & (rd_idx == mbox_reg_t'(`MBOX_REG_STAT));

   // same-cycle strobes to the mailboxes
   always_comb begin
      rd_lo = '0;
      rd_hi = '0;
      if (box_hit) begin
         rd_lo[box] = ~hi_sel;
         rd_hi[box] = hi_sel;
      end
   end

   // status bitmap, zero-extended
   always_ff @(posedge rd_clk or negedge arst_n) begin
      if (!arst_n) begin
         stat_q <= '0;
      end else if (stat_hit) begin
         stat_q <= {{(`MBOX_DW-`MBOX_NUM){1'b0}}, box_not_empty};
      end else begin
         stat_q <= '0;
      end
   end

   // only the addressed source is nonzero, so OR is the mux
   always_comb begin
      mi_dout = stat_q;
      for (int i = 0; i < `MBOX_NUM; i++) begin
         mi_dout = mi_dout | box_dout[i];
      end
   end

endmodule

//--- source/mailbox_top.sv
// mailbox block top with packet decoder, mailbox array and register read mux
`include "mbox_consts.svh"

module mailbox_top
   import mbox_pkg::*;
(
   input  logic                  wr_clk,
   input  logic                  rd_clk,
   input  logic                  arst_n,
   input  logic                  emesh_access,
   input  logic [`MBOX_PW-1:0]   emesh_packet,
   input  logic                  mi_en,
   input  logic                  mi_we,
   input  logic [`MBOX_RFAW+1:0] mi_addr,
   output logic [`MBOX_DW-1:0]   mi_dout,
   output logic [`MBOX_NUM-1:0]  box_not_empty,
   output logic [`MBOX_NUM-1:0]  box_full
);

   logic [`MBOX_NUM-1:0] push;             // wr_clk, one-hot
   mbox_entry_t          push_data;
   logic [`MBOX_NUM-1:0] rd_lo;            // rd_clk strobes
   logic [`MBOX_NUM-1:0] rd_hi;
   mbox_entry_t          box_dout [`MBOX_NUM];

   // write side
   emesh_decode u_decode (
      .wr_clk       (wr_clk),
      .arst_n       (arst_n),
      .emesh_access (emesh_access),
      .emesh_packet (emesh_packet),
      .push         (push),
      .push_data    (push_data)
   );

   // one mailbox per push bit
   for (genvar i = 0; i < `MBOX_NUM; i++) begin : g_box
      emailbox u_box (
         .rd_clk        (rd_clk),
         .wr_clk        (wr_clk),
         .arst_n        (arst_n),
         .push          (push[i]),
         .push_data     (push_data),    // shared, push picks the box
         .rd_lo         (rd_lo[i]),
         .rd_hi         (rd_hi[i]),
         .box_dout      (box_dout[i]),
         .box_not_empty (box_not_empty[i]),
         .box_full      (box_full[i])
      );
   end

   // read side
   mi_read_mux u_rmux (
      .rd_clk        (rd_clk),
      .arst_n        (arst_n),
      .mi_en         (mi_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .box_dout      (box_dout),
      .box_not_empty (box_not_empty),
      .rd_lo         (rd_lo),
      .rd_hi         (rd_hi),
      .mi_dout       (mi_dout)
   );

endmodule

//--- verification/mailbox_chk.sv
// concurrent assertions on push strobes, read strobes and idle read data
`include "mbox_consts.svh"

module mailbox_chk (
   input logic                 wr_clk,
   input logic                 rd_clk,
   input logic                 arst_n,
   input logic [`MBOX_NUM-1:0] push,
   input logic [`MBOX_NUM-1:0] rd_lo,
   input logic [`MBOX_NUM-1:0] rd_hi,
   input logic                 mi_en,
   input logic                 mi_we,
   input logic [`MBOX_DW-1:0]  mi_dout
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;                     // read back by the testbench

   // decoder targets at most one mailbox
   push_onehot: assert property (@(posedge wr_clk) disable iff (!arst_n) $onehot0(push))
      else begin
         fail_count++;
         $error("push strobe not one-hot: %b", push);
      end

   // a register index is either LO or HI
   lo_hi_excl: assert property (@(posedge rd_clk) disable iff (!arst_n) (rd_lo & rd_hi) == '0)
      else begin
         fail_count++;
         $error("rd_lo and rd_hi overlap: %b %b", rd_lo, rd_hi);
      end

   // no read, no data on the bus next cycle
   idle_dout_zero: assert property (@(posedge rd_clk) disable iff (!arst_n)
      !(mi_en && !mi_we) |=> (mi_dout == '0))
      else begin
         fail_count++;
         $error("mi_dout nonzero after idle cycle: %h", mi_dout);
      end

endmodule

//--- verification/mailbox_tb.sv
// mailbox block testbench with clocks, reset, case file stimulus, checks, watchdog and summary
`include "mbox_consts.svh"

module mailbox_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RD_PERIOD = 8;
   localparam int WR_PERIOD = 12;
   localparam int MAX_CASES = 64;
   localparam logic [63:0] FILL_STEP = 64'h0000_0001_0000_0001; // bumps both halves

   localparam logic [3:0] OP_PUSH     = 4'h0;
   localparam logic [3:0] OP_BAD_ID   = 4'h1;
   localparam logic [3:0] OP_BAD_PAGE = 4'h2;
   localparam logic [3:0] OP_BAD_WR   = 4'h3;
   localparam logic [3:0] OP_RD_LO    = 4'h4;
   localparam logic [3:0] OP_RD_HI    = 4'h5;
   localparam logic [3:0] OP_STAT     = 4'h6;
   localparam logic [3:0] OP_WAIT     = 4'h7;
   localparam logic [3:0] OP_FULL     = 4'h8;
   localparam logic [3:0] OP_FILL     = 4'h9;
   localparam logic [3:0] OP_DRAIN    = 4'ha;
   localparam logic [3:0] OP_END      = 4'hf;

   logic                  rd_clk;
   logic                  wr_clk;
   logic                  arst_n;
   logic                  emesh_access;
   logic [`MBOX_PW-1:0]   emesh_packet;
   logic                  mi_en;
   logic                  mi_we;
   logic [`MBOX_RFAW+1:0] mi_addr;
   logic [`MBOX_DW-1:0]   mi_dout;
   logic [`MBOX_NUM-1:0]  box_not_empty;
   logic [`MBOX_NUM-1:0]  box_full;

   logic [71:0] cases [MAX_CASES];         // op, box, data
   int          n_cases;
   int          n_checks;
   int          n_errors;
   logic        loaded;                    // starts the watchdog

   mailbox_top UUT (
      .wr_clk        (wr_clk),
      .rd_clk        (rd_clk),
      .arst_n        (arst_n),
      .emesh_access  (emesh_access),
      .emesh_packet  (emesh_packet),
      .mi_en         (mi_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .mi_dout       (mi_dout),
      .box_not_empty (box_not_empty),
      .box_full      (box_full)
   );

   bind mailbox_top mailbox_chk u_chk (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .arst_n  (arst_n),
      .push    (push),
      .rd_lo   (rd_lo),
      .rd_hi   (rd_hi),
      .mi_en   (mi_en),
      .mi_we   (mi_we),
      .mi_dout (mi_dout)
   );

   initial begin
      rd_clk = 1'b0;
      forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
   end

   initial begin
      wr_clk = 1'b0;
      forever #(WR_PERIOD / 2) wr_clk = ~wr_clk; // never aligns with rd_clk edges
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   function automatic logic [5:0] lo_idx(int box);
      return 6'(`MBOX_REG_BASE + 2 * box);   // HI sits right after
   endfunction

   task automatic send_packet(input logic [11:0] id, input logic [2:0] page, input logic wr,
                              input int box, input logic [63:0] data);
      logic [31:0] addr;
      addr = {id, 9'd0, page, lo_idx(box), 2'b00};
      @(posedge wr_clk);
      emesh_access <= 1'b1;
      emesh_packet <= {data, addr, 6'd0, wr, 1'b0};
      @(posedge wr_clk);                     // decoder registers push
      emesh_access <= 1'b0;
      emesh_packet <= '0;
      @(posedge wr_clk);                     // entry lands in the FIFO
   endtask

   task automatic reg_read(input logic [5:0] idx, output logic [63:0] data);
      @(posedge rd_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= {idx, 2'b00};
      @(posedge rd_clk);                     // read sampled, HI pops here
      mi_en   <= 1'b0;
      mi_addr <= '0;
      @(negedge rd_clk);                     // data valid this cycle
      data = mi_dout;
   endtask

   task automatic wait_irq(input int box);
      int n;
      n = 0;
      while (!box_not_empty[box] && n < 4) begin
         @(posedge rd_clk);
         #1;
         n++;
      end
      check($sformatf("box_not_empty[%0d]", box), 64'(box_not_empty[box]), 64'd1);
   endtask

   task automatic run_case(input logic [71:0] word);
      logic [3:0]  op;
      int          box;
      logic [63:0] val;
      logic [63:0] got;
      logic [63:0] item;
      op  = word[71:68];
      box = int'(word[67:64]);
      val = word[63:0];
      case (op)
         OP_PUSH:     send_packet(`MBOX_ID, `MBOX_PAGE, 1'b1, box, val);
         OP_BAD_ID:   send_packet(`MBOX_ID ^ 12'h001, `MBOX_PAGE, 1'b1, box, val);
         OP_BAD_PAGE: send_packet(`MBOX_ID, `MBOX_PAGE ^ 3'h1, 1'b1, box, val);
         OP_BAD_WR:   send_packet(`MBOX_ID, `MBOX_PAGE, 1'b0, box, val);
         OP_RD_LO: begin
            reg_read(lo_idx(box), got);
            check($sformatf("mi_dout lo box %0d", box), got, val);
         end
         OP_RD_HI: begin
            reg_read(lo_idx(box) + 6'd1, got);
            check($sformatf("mi_dout hi box %0d", box), got, val);
         end
         OP_STAT: begin
            reg_read(6'(`MBOX_REG_STAT), got);
            check("mi_dout status", got, val);
         end
         OP_WAIT: wait_irq(box);
         OP_FULL: begin
            repeat (4) @(posedge wr_clk);    // covers release latency
            #1;
            check("box_full", 64'(box_full), val);
         end
         OP_FILL: begin
            for (int i = 0; i <= `MBOX_DEPTH; i++) begin
               send_packet(`MBOX_ID, `MBOX_PAGE, 1'b1, box, val + i * FILL_STEP);
            end
         end
         OP_DRAIN: begin
            for (int i = 0; i < `MBOX_DEPTH; i++) begin
               item = val + i * FILL_STEP;
               reg_read(lo_idx(box) + 6'd1, got);
               check($sformatf("mi_dout drain box %0d", box), got, {item[63:32], item[63:32]});
            end
         end
         default: begin
            n_errors++;
            $display("Unknown operation %h in the case file", op);
         end
      endcase
   endtask

   initial begin
      arst_n       = 1'b0;
      emesh_access = 1'b0;
      emesh_packet = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      n_checks     = 0;
      n_errors     = 0;
      loaded       = 1'b0;
      for (int i = 0; i < MAX_CASES; i++) begin
         cases[i] = {OP_END, 68'd0};         // marks unused slots
      end
      $readmemh("verification/mailbox_cases.txt", cases);
      n_cases = 0;
      while (n_cases < MAX_CASES && cases[n_cases][71:68] != OP_END) begin
         n_cases++;
      end
      loaded = 1'b1;
      if (n_cases == 0) begin
         n_errors++;
         $display("No cases were read from the case file");
      end
      repeat (3) @(posedge rd_clk);
      arst_n <= 1'b1;
      @(negedge rd_clk);
      check("mi_dout", mi_dout, 64'd0);
      check("box_not_empty", 64'(box_not_empty), 64'd0);
      check("box_full", 64'(box_full), 64'd0);
      for (int i = 0; i < n_cases; i++) begin
         run_case(cases[i]);
      end
      repeat (4) @(posedge rd_clk);
      n_errors += UUT.u_chk.fail_count;     // assertion failures count too
      $display("Summary: %0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog, 40 rd_clk periods per case plus reset margin
   initial begin
      wait (loaded);
      #((n_cases * 40 + 10) * RD_PERIOD);
      n_errors += UUT.u_chk.fail_count + 1;
      $display("Timeout: the run did not finish in time, stopped at %0d ns", $time);
      $display("Summary: %0d cases, %0d checks, %0d errors", n_cases, n_checks, n_errors);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- verification/mailbox_cases.txt
// one 18-digit hex word per line: op digit, mailbox digit, 16 digits of data or expected value
// ops 0 push, 1 bad id, 2 bad page, 3 bad write flag, 4 read lo, 5 read hi, 6 status,
// 7 wait irq, 8 full bitmap, 9 fill box from base, a drain box from base, f end
101111111111111111  // rejected packets first
212222222222222222
323333333333333333
000123456789abcdef
700000000000000000
600000000000000001  // only box 0 holds data
400123456789abcdef
400123456789abcdef  // peek twice, same word
00fedcba9876543210
03a5a5a5a55a5a5a5a
730000000000000000
600000000000000009
500123456701234567  // pops A
40fedcba9876543210
50fedcba98fedcba98
600000000000000008
43a5a5a5a55a5a5a5a
53a5a5a5a5a5a5a5a5
921000000020000000  // depth plus one, last dropped
720000000000000000
800000000000000004
600000000000000004
a21000000020000000
600000000000000000
800000000000000000  // full released after drain
f00000000000000000

//--- sim.f
+incdir+source
source/mbox_pkg.sv
source/emesh_decode.sv
source/fifo_async.sv
source/emailbox.sv
source/mi_read_mux.sv
source/mailbox_top.sv
verification/mailbox_chk.sv
verification/mailbox_tb.sv
